// ==== logic/buf_params.svh ====
`ifndef BUF_PARAMS_SVH
`define BUF_PARAMS_SVH

// Stream byte width
`define BUF_BYTE_W 8

// FIFO word width, holds two bytes
`define BUF_WORD_W 16

// FIFO entries
`define BUF_DEPTH 8

// Almost-full count, one below depth
`define BUF_AF_THRESHOLD 7

`endif

// ==== logic/buf_pkg.sv ====
`include "buf_params.svh"

package buf_pkg;

  // Byte view of one FIFO word, hi byte in the upper half
  typedef struct packed {
    logic [`BUF_BYTE_W-1:0] hi;  // Second byte of the pair
    logic [`BUF_BYTE_W-1:0] lo;  // First byte of the pair
  } buf_bytes_t;

  // One stored word, seen whole or as two bytes
  typedef union packed {
    logic [`BUF_WORD_W-1:0] word;   // As the FIFO stores it
    buf_bytes_t             bytes;  // As packer and unpacker see it
  } buf_word_u;

endpackage

// ==== logic/fifo_wr_if.sv ====
`timescale 1ns/1ps

interface fifo_wr_if;

  logic               wr_en;        // Write strobe
  buf_pkg::buf_word_u wr_data;      // Word to store
  logic               full;         // No free entry
  logic               almost_full;  // Count at or above threshold

  modport packer (
    output wr_en,
    output wr_data,
    input  full,
    input  almost_full
  );

  modport fifo (
    input  wr_en,
    input  wr_data,
    output full,
    output almost_full
  );

endinterface

// ==== logic/fifo.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module fifo #(
  parameter int FIFO_DEPTH        = `BUF_DEPTH,
  parameter int FIFO_AF_THRESHOLD = `BUF_AF_THRESHOLD
) (
  input  logic               clk,
  input  logic               rst_n,
  fifo_wr_if.fifo            wr,
  input  logic               rd_en,
  output buf_pkg::buf_word_u rd_data,
  output logic               empty
);

  localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;  // At least one bit
  localparam int CNT_W  = ADDR_W + 1;  // Must reach FIFO_DEPTH itself

  buf_pkg::buf_word_u mem [FIFO_DEPTH];  // Word storage
  logic [ADDR_W-1:0]  wr_ptr;            // Next slot to write
  logic [ADDR_W-1:0]  rd_ptr;            // Next slot to read
  logic [CNT_W-1:0]   count;             // Words held
  logic               wr_ok;             // Write accepted this cycle
  logic               rd_ok;             // Read accepted this cycle

  assign wr_ok = wr.wr_en;          // Packer never writes while full
  assign rd_ok = rd_en && !empty;   // Reads on empty ignored

  // Flags decoded from the count
  assign wr.full        = (count == CNT_W'(FIFO_DEPTH));
  assign wr.almost_full = (count >= CNT_W'(FIFO_AF_THRESHOLD));
  assign empty          = (count == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;  // Wrap at depth
      end
      case ({rd_ok, wr_ok})
        2'b10:   count <= count - 1'b1;  // Read only
        2'b01:   count <= count + 1'b1;  // Write only
        default: count <= count;         // Idle or both
      endcase
    end
  end

  // Storage and registered read port
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr.wr_data;
    end
    if (rd_ok) begin
      rd_data <= mem[rd_ptr];  // Holds last word between reads
    end
  end

endmodule

// ==== logic/byte_packer.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module byte_packer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`BUF_BYTE_W-1:0] byte_in,
  input  logic                   byte_in_valid,
  fifo_wr_if.packer              wr,
  output logic                   overflow
);

  logic                   half_q;  // Lo byte waiting for its partner
  logic [`BUF_BYTE_W-1:0] lo_q;    // First byte of the pair
  logic                   pair_c;  // Second byte strobing now
  buf_pkg::buf_word_u     word_c;  // Assembled word

  assign pair_c = byte_in_valid && half_q;

  // New byte goes straight into the hi half
  always_comb begin
    word_c.bytes.lo = lo_q;
    word_c.bytes.hi = byte_in;
  end

  assign wr.wr_data = word_c;
  assign wr.wr_en   = pair_c && !wr.full;  // Same-cycle write, dropped when full

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_q   <= 1'b0;
      overflow <= 1'b0;
    end else begin
      if (byte_in_valid) begin
        half_q <= !half_q;  // Back to empty-half after a pair
      end
      if (pair_c && wr.full) begin
        overflow <= 1'b1;  // Sticky until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_in_valid && !half_q) begin
      lo_q <= byte_in;  // Capture first byte
    end
  end

endmodule

// ==== logic/word_unpacker.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module word_unpacker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   out_en,
  output logic                   rd_en,
  input  buf_pkg::buf_word_u     rd_data,
  input  logic                   empty,
  output logic [`BUF_BYTE_W-1:0] byte_out,
  output logic                   byte_out_valid
);

  logic               pend_q;     // Word waiting on rd_data
  buf_pkg::buf_word_u hold_q;     // Word being emitted
  logic [1:0]         cnt_q;      // Bytes left in hold_q
  logic               hold_free;  // hold_q empty by next edge
  logic               load;       // Move rd_data into hold_q

  // Free if already empty or last byte leaves this cycle
  assign hold_free = out_en && (cnt_q == 2'd0 || cnt_q == 2'd1);
  assign load      = pend_q && hold_free;

  // Request lands on rd_data next edge and is loaded one cycle later,
  // so asking in the hi-byte cycle keeps words back to back
  assign rd_en = hold_free && !empty;

  assign byte_out_valid = out_en && (cnt_q != 2'd0);  // Frozen while out_en low
  assign byte_out       = (cnt_q == 2'd2) ? hold_q.bytes.lo : hold_q.bytes.hi;  // Lo first

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
      cnt_q  <= 2'd0;
    end else begin
      if (rd_en) begin
        pend_q <= 1'b1;  // New word arrives on rd_data
      end else if (load) begin
        pend_q <= 1'b0;  // Word taken, nothing behind it
      end
      if (load) begin
        cnt_q <= 2'd2;  // Fresh word, both bytes
      end else if (byte_out_valid) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      hold_q <= rd_data;
    end
  end

endmodule

// ==== logic/byte_buffer_top.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module byte_buffer_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`BUF_BYTE_W-1:0] byte_in,
  input  logic                   byte_in_valid,
  input  logic                   out_en,
  output logic [`BUF_BYTE_W-1:0] byte_out,
  output logic                   byte_out_valid,
  output logic                   almost_full,
  output logic                   overflow
);

  fifo_wr_if          wr_bus ();  // Packer to FIFO
  logic               rd_en;      // Unpacker read strobe
  buf_pkg::buf_word_u rd_data;    // Registered FIFO output
  logic               empty;      // FIFO has no words

  assign almost_full = wr_bus.almost_full;  // Upstream warning

  byte_packer i_packer (
    .clk           (clk),
    .rst_n         (rst_n),
    .byte_in       (byte_in),
    .byte_in_valid (byte_in_valid),
    .wr            (wr_bus.packer),
    .overflow      (overflow)
  );

  fifo i_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr_bus.fifo),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (empty)
  );

  word_unpacker i_unpacker (
    .clk            (clk),
    .rst_n          (rst_n),
    .out_en         (out_en),
    .rd_en          (rd_en),
    .rd_data        (rd_data),
    .empty          (empty),
    .byte_out       (byte_out),
    .byte_out_valid (byte_out_valid)
  );

endmodule

// ==== tb/byte_buffer_tb.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module byte_buffer_tb;

  localparam int HALF_PERIOD = 10;   // 20 ns clock
  localparam int RST_CYCLES  = 5;
  localparam int WAIT_LIMIT  = 200;  // Cycles allowed per output byte
  localparam int SEED        = 99;

  logic                   clk;
  logic                   rst_n;
  logic [`BUF_BYTE_W-1:0] byte_in;
  logic                   byte_in_valid;
  logic                   out_en;
  logic [`BUF_BYTE_W-1:0] byte_out;
  logic                   byte_out_valid;
  logic                   almost_full;
  logic                   overflow;

  logic [`BUF_BYTE_W-1:0] seen_q[$];    // Output bytes not yet checked
  int                     errors;
  int                     tests_run;
  int                     tests_failed;
  int                     test_err0;    // Errors before current test
  int                     gap_max;      // Max idle cycles after a strobe
  string                  test_name;

  byte_buffer_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .byte_in        (byte_in),
    .byte_in_valid  (byte_in_valid),
    .out_en         (out_en),
    .byte_out       (byte_out),
    .byte_out_valid (byte_out_valid),
    .almost_full    (almost_full),
    .overflow       (overflow)
  );

  always #HALF_PERIOD clk = ~clk;

  // Sampled mid-cycle where outputs have settled
  always @(negedge clk) begin
    if (rst_n && byte_out_valid) begin
      seen_q.push_back(byte_out);
      if (!out_en) begin
        $display("Output valid while out_en was low in test %s", test_name);
        errors++;
      end
    end
  end

  task automatic step();
    @(posedge clk);
    #1;  // Just after the edge
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      step();
    end
  endtask

  task automatic apply_reset();
    rst_n         = 1'b0;
    byte_in_valid = 1'b0;
    idle(RST_CYCLES);
    rst_n = 1'b1;
    step();
  endtask

  // One strobe followed by an optional random gap
  task automatic push_byte(input logic [`BUF_BYTE_W-1:0] b);
    int gap;
    byte_in       = b;
    byte_in_valid = 1'b1;
    step();
    byte_in_valid = 1'b0;
    gap = (gap_max > 0) ? int'($urandom % (gap_max + 1)) : 0;
    idle(gap);
  endtask

  task automatic next_byte(output logic [`BUF_BYTE_W-1:0] b, output bit ok);
    int t;
    t = 0;
    while (seen_q.size() == 0 && t < WAIT_LIMIT) begin
      step();
      t++;
    end
    ok = (seen_q.size() != 0);
    b  = '0;
    if (ok) begin
      b = seen_q.pop_front();
    end else begin
      $display("Timed out waiting for an output byte in test %s", test_name);
      errors++;
    end
  endtask

  task automatic check_byte(input logic [`BUF_BYTE_W-1:0] got, input logic [`BUF_BYTE_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch byte_out: got 0x%h, expected 0x%h", got, exp);
      errors++;
    end
  endtask

  task automatic check_flags(input logic af_got, input logic ov_got,
                             input logic af_exp, input logic ov_exp);
    if (af_got !== af_exp) begin
      $display("Mismatch almost_full: got 0x%h, expected 0x%h", af_got, af_exp);
      errors++;
    end
    if (ov_got !== ov_exp) begin
      $display("Mismatch overflow: got 0x%h, expected 0x%h", ov_got, ov_exp);
      errors++;
    end
  endtask

  task automatic check_word(input buf_pkg::buf_word_u got, input buf_pkg::buf_word_u exp);
    if (got.word !== exp.word) begin
      $display("Mismatch byte_out pair: got 0x%h, expected 0x%h", got.word, exp.word);
      errors++;
    end
  endtask

  task automatic expect_byte(input logic [`BUF_BYTE_W-1:0] exp);
    logic [`BUF_BYTE_W-1:0] b;
    bit                     ok;
    next_byte(b, ok);
    if (ok) begin
      check_byte(b, exp);
    end
  endtask

  // First byte out is the lo half
  task automatic expect_word(input logic [`BUF_WORD_W-1:0] w);
    buf_pkg::buf_word_u exp_w;
    buf_pkg::buf_word_u got_w;
    bit                 ok_lo;
    bit                 ok_hi;
    exp_w.word = w;
    next_byte(got_w.bytes.lo, ok_lo);
    next_byte(got_w.bytes.hi, ok_hi);
    if (ok_lo && ok_hi) begin
      check_word(got_w, exp_w);
    end
  endtask

  task automatic check_quiet();
    if (seen_q.size() != 0) begin
      $display("Unexpected output: %0d byte(s) seen in test %s", seen_q.size(), test_name);
      errors++;
      seen_q.delete();
    end
  endtask

  task automatic finish_test();
    check_quiet();
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
      $display("Test %s: FAILED", test_name);
    end else begin
      $display("Test %s: ok", test_name);
    end
  endtask

  task automatic run_commands(input int fd);
    string                  cmd;
    string                  rest;
    int                     code;
    int                     n;
    logic [`BUF_WORD_W-1:0] val;
    logic [`BUF_WORD_W-1:0] val2;
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd.getc(0) == "#") begin
        code = $fgets(rest, fd);  // Skip comment
      end else if (cmd == "test") begin
        code      = $fscanf(fd, "%s", test_name);
        test_err0 = errors;
      end else if (cmd == "en") begin
        code   = $fscanf(fd, "%h", val);
        out_en = val[0];
      end else if (cmd == "gap") begin
        code = $fscanf(fd, "%d", gap_max);
      end else if (cmd == "idle") begin
        code = $fscanf(fd, "%d", n);
        idle(n);
      end else if (cmd == "reset") begin
        apply_reset();
      end else if (cmd == "push" || cmd == "expb" || cmd == "expw") begin
        code = $fscanf(fd, "%d", n);  // Count comes before the data
        for (int i = 0; i < n; i++) begin
          code = $fscanf(fd, "%h", val);
          if (cmd == "push") begin
            push_byte(val[`BUF_BYTE_W-1:0]);
          end else if (cmd == "expb") begin
            expect_byte(val[`BUF_BYTE_W-1:0]);
          end else begin
            expect_word(val);
          end
        end
      end else if (cmd == "flags") begin
        code = $fscanf(fd, "%h %h", val, val2);
        check_flags(almost_full, overflow, val[0], val2[0]);
      end else if (cmd == "noout") begin
        check_quiet();
      end else if (cmd == "end") begin
        finish_test();
      end else begin
        $display("Unknown stimulus command %s", cmd);
        errors++;
      end
    end
  endtask

  initial begin
    int fd;
    clk           = 1'b0;
    rst_n         = 1'b0;
    byte_in       = '0;
    byte_in_valid = 1'b0;
    out_en        = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err0     = 0;
    gap_max       = 0;
    test_name     = "init";
    void'($urandom(SEED));
    apply_reset();
    fd = $fopen("tb/byte_buffer_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      errors++;
    end else begin
      run_commands(fd);
      $fclose(fd);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && tests_run > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== tb/byte_buffer_stimulus.txt ====
# Columns: command, then operands (counts decimal, data hex)
# test name | en v | gap max | push n b.. | expb n b.. | expw n w.. | flags af ov | idle n | noout | reset | end
test order
en 1
push 6 11 22 33 44 55 66
expw 3 2211 4433 6655
idle 4
end
test unpaired
en 1
push 1 a5
idle 6
noout
push 1 5a
expb 2 a5 5a
idle 4
end
test almost_full
en 0
push 12 01 02 03 04 05 06 07 08 09 0a 0b 0c
flags 0 0
push 2 0d 0e
flags 1 0
push 2 0f 10
flags 1 0
end
test overflow
en 0
push 2 ee ff
flags 1 1
en 1
expw 8 0201 0403 0605 0807 0a09 0c0b 0e0d 100f
idle 6
flags 0 1
end
test stall
gap 3
en 1
push 8 10 11 12 13 14 15 16 17
en 0
push 8 18 19 1a 1b 1c 1d 1e 1f
en 1
push 4 20 21 22 23
en 0
idle 3
en 1
expb 20 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23
gap 0
idle 4
flags 0 1
end
test reset
en 0
push 3 aa bb cc
flags 0 1
reset
flags 0 0
en 1
idle 8
noout
push 2 12 34
expw 1 3412
idle 4
end

// ==== build.f ====
+incdir+logic
logic/buf_pkg.sv
logic/fifo_wr_if.sv
logic/fifo.sv
logic/byte_packer.sv
logic/word_unpacker.sv
logic/byte_buffer_top.sv
tb/byte_buffer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= byte_buffer_tb
RTL_TOP   ?= byte_buffer_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
